//--- src/lsu_map_pkg.sv
package lsu_map_pkg;

    // data path and address width
    localparam int xlen = 32;
    // byte lanes per word
    localparam int nbytes = xlen / 8;

    // clint timer words, each one word wide
    localparam logic [xlen-1:0] mtime_lo_addr    = 32'h0200_bff8;
    localparam logic [xlen-1:0] mtime_hi_addr    = 32'h0200_bffc;
    localparam logic [xlen-1:0] mtimecmp_lo_addr = 32'h0200_4000;
    localparam logic [xlen-1:0] mtimecmp_hi_addr = 32'h0200_4004;

endpackage

//--- src/lsu_op_pkg.sv
package lsu_op_pkg;

    // memory opcode as issued by the execute stage
    typedef enum logic [3:0] {
        memop_none = 4'd0,
        memop_lb   = 4'd1,
        memop_lbu  = 4'd2,
        memop_lh   = 4'd3,
        memop_lhu  = 4'd4,
        memop_lw   = 4'd5,
        memop_sb   = 4'd6,
        memop_sh   = 4'd7,
        memop_sw   = 4'd8,
        memop_lr_w = 4'd9,
        memop_sc_w = 4'd10,
        memop_amo  = 4'd11
    } memop_t;

    // amo sub-opcode, only looked at with memop_amo
    typedef enum logic [3:0] {
        amoop_swap = 4'd0,
        amoop_add  = 4'd1,
        amoop_xor  = 4'd2,
        amoop_and  = 4'd3,
        amoop_or   = 4'd4,
        amoop_min  = 4'd5,
        amoop_max  = 4'd6,
        amoop_minu = 4'd7,
        amoop_maxu = 4'd8
    } amoop_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_t;

    // one-hot class plus access shape
    typedef struct packed {
        logic      is_load;
        logic      is_store;
        logic      is_lr;
        logic      is_sc;
        logic      is_amo;
        lsu_size_t size;
        logic      sign_ext;
        amoop_t    amo_op;
    } lsu_dec_t;

    typedef struct packed {
        memop_t                        op;
        amoop_t                        amo_op;
        logic [lsu_map_pkg::xlen-1:0]  addr;
        logic [lsu_map_pkg::xlen-1:0]  wdata;
    } lsu_req_t;

    // shared shape of the cache and clint requests
    typedef struct packed {
        logic [lsu_map_pkg::xlen-1:0]   addr;
        logic [lsu_map_pkg::xlen-1:0]   wdata;
        logic [lsu_map_pkg::nbytes-1:0] strb;
        logic                           we;
    } bus_req_t;

endpackage

//--- src/lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode (
    input  lsu_op_pkg::memop_t   op_i,
    input  lsu_op_pkg::amoop_t   amo_op_i,
    output lsu_op_pkg::lsu_dec_t dec_o
);

    always_comb begin
        // unknown codes fall out as no operation
        dec_o = '0;
        dec_o.amo_op = amo_op_i;
        case (op_i)
            lsu_op_pkg::memop_lb: begin
                dec_o.is_load  = 1'b1;
                dec_o.size     = lsu_op_pkg::size_byte;
                dec_o.sign_ext = 1'b1;
            end
            lsu_op_pkg::memop_lbu: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = lsu_op_pkg::size_byte;
            end
            lsu_op_pkg::memop_lh: begin
                dec_o.is_load  = 1'b1;
                dec_o.size     = lsu_op_pkg::size_half;
                dec_o.sign_ext = 1'b1;
            end
            lsu_op_pkg::memop_lhu: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = lsu_op_pkg::size_half;
            end
            lsu_op_pkg::memop_lw: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = lsu_op_pkg::size_word;
            end
            lsu_op_pkg::memop_sb: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = lsu_op_pkg::size_byte;
            end
            lsu_op_pkg::memop_sh: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = lsu_op_pkg::size_half;
            end
            lsu_op_pkg::memop_sw: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = lsu_op_pkg::size_word;
            end
            // atomics are always a full word
            lsu_op_pkg::memop_lr_w: begin
                dec_o.is_lr = 1'b1;
                dec_o.size  = lsu_op_pkg::size_word;
            end
            lsu_op_pkg::memop_sc_w: begin
                dec_o.is_sc = 1'b1;
                dec_o.size  = lsu_op_pkg::size_word;
            end
            lsu_op_pkg::memop_amo: begin
                dec_o.is_amo = 1'b1;
                dec_o.size   = lsu_op_pkg::size_word;
            end
            default: begin
                dec_o.size = lsu_op_pkg::size_byte;
            end
        endcase
    end

endmodule

//--- src/lsu_lane.sv
`timescale 1ns/1ps

module lsu_lane (
    input  lsu_op_pkg::lsu_dec_t              dec_i,
    input  logic [1:0]                        offset_i,
    input  logic [lsu_map_pkg::xlen-1:0]      store_data_i,
    input  logic [lsu_map_pkg::xlen-1:0]      rdata_i,
    output logic [lsu_map_pkg::nbytes-1:0]    strb_o,
    output logic [lsu_map_pkg::xlen-1:0]      wdata_o,
    output logic [lsu_map_pkg::xlen-1:0]      load_data_o
);

    logic [lsu_map_pkg::nbytes-1:0] size_mask;
    logic [4:0]                     bit_shift;
    logic [lsu_map_pkg::xlen-1:0]   rdata_shifted;

    // byte offset as a bit shift
    assign bit_shift = {offset_i, 3'b000};

    always_comb begin
        case (dec_i.size)
            lsu_op_pkg::size_byte: size_mask = 4'b0001;
            lsu_op_pkg::size_half: size_mask = 4'b0011;
            default:               size_mask = 4'b1111;
        endcase
    end

    // store side, low bytes move up to their lane
    assign strb_o  = size_mask << offset_i;
    assign wdata_o = store_data_i << bit_shift;

    // load side, addressed byte moves down to bit 0
    assign rdata_shifted = rdata_i >> bit_shift;

    always_comb begin
        case (dec_i.size)
            lsu_op_pkg::size_byte: begin
                load_data_o = {{24{dec_i.sign_ext & rdata_shifted[7]}}, rdata_shifted[7:0]};
            end
            lsu_op_pkg::size_half: begin
                load_data_o = {{16{dec_i.sign_ext & rdata_shifted[15]}}, rdata_shifted[15:0]};
            end
            default: begin
                load_data_o = rdata_shifted;
            end
        endcase
    end

endmodule

//--- src/amo_alu.sv
`timescale 1ns/1ps

module amo_alu (
    input  lsu_op_pkg::amoop_t           amo_op_i,
    input  logic [lsu_map_pkg::xlen-1:0] old_i,
    input  logic [lsu_map_pkg::xlen-1:0] operand_i,
    output logic [lsu_map_pkg::xlen-1:0] new_o
);

    logic lt_signed;
    logic lt_unsigned;

    // one compare each way serves both min and max
    assign lt_signed   = $signed(old_i) < $signed(operand_i);
    assign lt_unsigned = old_i < operand_i;

    always_comb begin
        case (amo_op_i)
            lsu_op_pkg::amoop_swap: new_o = operand_i;
            lsu_op_pkg::amoop_add:  new_o = old_i + operand_i;
            lsu_op_pkg::amoop_xor:  new_o = old_i ^ operand_i;
            lsu_op_pkg::amoop_and:  new_o = old_i & operand_i;
            lsu_op_pkg::amoop_or:   new_o = old_i | operand_i;
            lsu_op_pkg::amoop_min:  new_o = lt_signed ? old_i : operand_i;
            lsu_op_pkg::amoop_max:  new_o = lt_signed ? operand_i : old_i;
            lsu_op_pkg::amoop_minu: new_o = lt_unsigned ? old_i : operand_i;
            lsu_op_pkg::amoop_maxu: new_o = lt_unsigned ? operand_i : old_i;
            // unused codes behave as swap
            default:                new_o = operand_i;
        endcase
    end

endmodule

//--- src/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid_i,
    input  lsu_op_pkg::lsu_req_t            req_i,
    input  lsu_op_pkg::lsu_dec_t            dec_i,
    input  logic [lsu_map_pkg::nbytes-1:0]  strb_i,
    input  logic [lsu_map_pkg::xlen-1:0]    lane_wdata_i,
    input  logic [lsu_map_pkg::xlen-1:0]    load_data_i,
    input  logic [lsu_map_pkg::xlen-1:0]    amo_new_i,
    input  logic                            mem_ready_i,
    input  logic [lsu_map_pkg::xlen-1:0]    mem_rdata_i,
    input  logic [lsu_map_pkg::xlen-1:0]    clint_rdata_i,
    output lsu_op_pkg::lsu_req_t            req_q_o,
    output logic [lsu_map_pkg::xlen-1:0]    rdata_q_o,
    output lsu_op_pkg::bus_req_t            mem_req_o,
    output logic                            mem_req_valid_o,
    output lsu_op_pkg::bus_req_t            clint_req_o,
    output logic                            clint_valid_o,
    output logic                            resp_valid_o,
    output logic [lsu_map_pkg::xlen-1:0]    resp_data_o,
    output logic                            resp_misalign_o,
    output logic                            busy_o
);

    typedef enum logic [2:0] {
        st_idle,
        st_access,
        st_calc,
        st_write,
        st_respond
    } state_t;

    state_t                         state_q;
    lsu_op_pkg::lsu_req_t           req_q;
    logic [lsu_map_pkg::xlen-1:0]   rdata_q;
    logic [lsu_map_pkg::xlen-1:0]   wdata_q;
    logic                           resv_valid_q;
    logic [lsu_map_pkg::xlen-1:0]   resv_addr_q;
    logic                           sc_fail_q;
    logic                           misalign_q;
    logic                           is_atomic;
    logic                           misaligned;
    logic                           clint_hit;
    logic                           sc_ok;
    logic                           bus_go;
    logic                           access_done;

    assign is_atomic  = dec_i.is_lr | dec_i.is_sc | dec_i.is_amo;
    assign misaligned = is_atomic & (req_q.addr[1:0] != 2'b00);

    // atomics never leave through the clint
    assign clint_hit = ~is_atomic &
                       ((req_q.addr == lsu_map_pkg::mtime_lo_addr) |
                        (req_q.addr == lsu_map_pkg::mtime_hi_addr) |
                        (req_q.addr == lsu_map_pkg::mtimecmp_lo_addr) |
                        (req_q.addr == lsu_map_pkg::mtimecmp_hi_addr));

    // reservation only changes when access ends, so this holds while waiting
    assign sc_ok = resv_valid_q & (resv_addr_q == req_q.addr);

    // failed sc and misaligned atomics skip the bus entirely
    assign bus_go = (dec_i.is_load | dec_i.is_store | is_atomic) & ~misaligned &
                    ~(dec_i.is_sc & ~sc_ok);

    assign clint_valid_o   = (state_q == st_access) & bus_go & clint_hit;
    assign mem_req_valid_o = ((state_q == st_access) & bus_go & ~clint_hit) |
                             (state_q == st_write);

    assign access_done = (state_q == st_access) &
                         (~bus_go | clint_hit | mem_ready_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= st_idle;
            resv_valid_q <= 1'b0;
            sc_fail_q    <= 1'b0;
            misalign_q   <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req_valid_i) begin
                        state_q <= st_access;
                    end
                end
                st_access: begin
                    if (access_done) begin
                        misalign_q <= misaligned;
                        sc_fail_q  <= ~sc_ok;
                        // amo read goes on to calc, everything else answers
                        if (bus_go & ~clint_hit & dec_i.is_amo) begin
                            state_q <= st_calc;
                        end else begin
                            state_q <= st_respond;
                        end
                        // sc and plain stores drop it, aligned lr takes it
                        if (dec_i.is_sc | dec_i.is_store) begin
                            resv_valid_q <= 1'b0;
                        end else if (dec_i.is_lr & ~misaligned) begin
                            resv_valid_q <= 1'b1;
                        end
                    end
                end
                st_calc: begin
                    state_q <= st_write;
                end
                st_write: begin
                    if (mem_ready_i) begin
                        state_q <= st_respond;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req_valid_i) begin
            req_q <= req_i;
        end
        // raw word from whichever port answered
        if (clint_valid_o) begin
            rdata_q <= clint_rdata_i;
        end else if ((state_q == st_access) && mem_req_valid_o && mem_ready_i) begin
            rdata_q <= mem_rdata_i;
        end
        // amo result held steady through the write transfer
        if (state_q == st_calc) begin
            wdata_q <= amo_new_i;
        end
        if (access_done && dec_i.is_lr && !misaligned) begin
            resv_addr_q <= req_q.addr;
        end
    end

    always_comb begin
        mem_req_o.addr = req_q.addr;
        if (state_q == st_write) begin
            mem_req_o.wdata = wdata_q;
            mem_req_o.strb  = '1;
            mem_req_o.we    = 1'b1;
        end else begin
            mem_req_o.wdata = lane_wdata_i;
            mem_req_o.strb  = strb_i;
            mem_req_o.we    = dec_i.is_store | dec_i.is_sc;
        end
    end

    // clint is word wide, lane strobe still marks the bytes
    assign clint_req_o.addr  = req_q.addr;
    assign clint_req_o.wdata = lane_wdata_i;
    assign clint_req_o.strb  = strb_i;
    assign clint_req_o.we    = dec_i.is_store;

    always_comb begin
        if (misalign_q) begin
            resp_data_o = '0;
        end else if (dec_i.is_load) begin
            resp_data_o = load_data_i;
        end else if (dec_i.is_lr | dec_i.is_amo) begin
            // old memory word
            resp_data_o = rdata_q;
        end else if (dec_i.is_sc) begin
            resp_data_o = {{(lsu_map_pkg::xlen-1){1'b0}}, sc_fail_q};
        end else begin
            resp_data_o = '0;
        end
    end

    assign resp_valid_o    = state_q == st_respond;
    assign resp_misalign_o = resp_valid_o & misalign_q;
    assign busy_o          = state_q != st_idle;
    assign req_q_o         = req_q;
    assign rdata_q_o       = rdata_q;

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid_i,
    input  lsu_op_pkg::lsu_req_t         req_i,
    output lsu_op_pkg::bus_req_t         mem_req_o,
    output logic                         mem_req_valid_o,
    input  logic                         mem_ready_i,
    input  logic [lsu_map_pkg::xlen-1:0] mem_rdata_i,
    output lsu_op_pkg::bus_req_t         clint_req_o,
    output logic                         clint_valid_o,
    input  logic [lsu_map_pkg::xlen-1:0] clint_rdata_i,
    output logic                         resp_valid_o,
    output logic [lsu_map_pkg::xlen-1:0] resp_data_o,
    output logic                         resp_misalign_o,
    output logic                         busy_o
);

    lsu_op_pkg::lsu_req_t           req_q;
    lsu_op_pkg::lsu_dec_t           dec;
    logic [lsu_map_pkg::nbytes-1:0] strb;
    logic [lsu_map_pkg::xlen-1:0]   lane_wdata;
    logic [lsu_map_pkg::xlen-1:0]   load_data;
    logic [lsu_map_pkg::xlen-1:0]   rdata_q;
    logic [lsu_map_pkg::xlen-1:0]   amo_new;

    // decode and lanes run on the latched request
    lsu_decode i_decode (
        .op_i     (req_q.op),
        .amo_op_i (req_q.amo_op),
        .dec_o    (dec)
    );

    lsu_lane i_lane (
        .dec_i        (dec),
        .offset_i     (req_q.addr[1:0]),
        .store_data_i (req_q.wdata),
        .rdata_i      (rdata_q),
        .strb_o       (strb),
        .wdata_o      (lane_wdata),
        .load_data_o  (load_data)
    );

    // old word against the latched store operand
    amo_alu i_amo_alu (
        .amo_op_i  (dec.amo_op),
        .old_i     (rdata_q),
        .operand_i (req_q.wdata),
        .new_o     (amo_new)
    );

    lsu_ctrl i_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .dec_i           (dec),
        .strb_i          (strb),
        .lane_wdata_i    (lane_wdata),
        .load_data_i     (load_data),
        .amo_new_i       (amo_new),
        .mem_ready_i     (mem_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .clint_rdata_i   (clint_rdata_i),
        .req_q_o         (req_q),
        .rdata_q_o       (rdata_q),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .clint_req_o     (clint_req_o),
        .clint_valid_o   (clint_valid_o),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o),
        .resp_misalign_o (resp_misalign_o),
        .busy_o          (busy_o)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // starts low at time zero
    initial begin
        clk_o = 1'b0;
    end

    // 40 ns period, 20 ns per half
    always begin
        #20 clk_o = ~clk_o;
    end

endmodule

//--- testbench/lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
    input logic                 clk,
    input logic                 rst,
    input lsu_op_pkg::bus_req_t mem_req_i,
    input logic                 mem_req_valid_i,
    input logic                 mem_ready_i,
    input logic                 clint_valid_i,
    input logic                 resp_valid_i
);

    // stalled cache request holds still until ready
    req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_i && !mem_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else $error("cache request changed while waiting for ready");

    // one port at a time
    port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(clint_valid_i && mem_req_valid_i))
    else $error("clint and cache requests overlap");

    // response is a single-cycle strobe
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid_i |=> !resp_valid_i)
    else $error("resp_valid_o held for more than one cycle");

endmodule

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    // one stimulus row with its expected response
    typedef struct packed {
        lsu_op_pkg::memop_t op;
        lsu_op_pkg::amoop_t amo_op;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        logic [31:0]        exp_data;
        logic               exp_misalign;
        int                 exp_xfers;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic                 req_valid_i;
    lsu_op_pkg::lsu_req_t req_i;
    lsu_op_pkg::bus_req_t mem_req_o;
    logic                 mem_req_valid_o;
    logic                 mem_ready_i = 1'b0;
    logic [31:0]          mem_rdata_i = 32'h0;
    lsu_op_pkg::bus_req_t clint_req_o;
    logic                 clint_valid_o;
    logic [31:0]          clint_rdata_i;
    logic                 resp_valid_o;
    logic [31:0]          resp_data_o;
    logic                 resp_misalign_o;
    logic                 busy_o;

    row_t        rows[$];
    logic        rows_ready = 1'b0;
    // 16-word cache model, every byte starts as its word index
    logic [31:0] mem [16] = '{32'hc0c0_c0c0, 32'hc1c1_c1c1, 32'hc2c2_c2c2, 32'hc3c3_c3c3,
                              32'hc4c4_c4c4, 32'hc5c5_c5c5, 32'hc6c6_c6c6, 32'hc7c7_c7c7,
                              32'hc8c8_c8c8, 32'hc9c9_c9c9, 32'hcaca_caca, 32'hcbcb_cbcb,
                              32'hcccc_cccc, 32'hcdcd_cdcd, 32'hcece_cece, 32'hcfcf_cfcf};
    // mtime lo/hi, mtimecmp lo/hi
    logic [31:0] clint_regs [4] = '{32'h0001_2345, 32'h0, 32'hffff_ffff, 32'hffff_ffff};
    integer      seed = 38;
    int          wait_left = 0;
    int          xfer_count = 0;
    int          checks;
    int          errors;

    tb_clock i_clock (
        .clk_o (clk)
    );

    lsu_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_ready_i     (mem_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .clint_req_o     (clint_req_o),
        .clint_valid_o   (clint_valid_o),
        .clint_rdata_i   (clint_rdata_i),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o),
        .resp_misalign_o (resp_misalign_o),
        .busy_o          (busy_o)
    );

    // port checks sit on the control block
    bind lsu_ctrl lsu_properties i_properties (
        .clk             (clk),
        .rst             (rst),
        .mem_req_i       (mem_req_o),
        .mem_req_valid_i (mem_req_valid_o),
        .mem_ready_i     (mem_ready_i),
        .clint_valid_i   (clint_valid_o),
        .resp_valid_i    (resp_valid_o)
    );

    // byte-wise write under a strobe
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic int clint_slot(input logic [31:0] addr);
        int slot;
        case (addr)
            lsu_map_pkg::mtime_hi_addr:    slot = 1;
            lsu_map_pkg::mtimecmp_lo_addr: slot = 2;
            lsu_map_pkg::mtimecmp_hi_addr: slot = 3;
            default:                       slot = 0;
        endcase
        return slot;
    endfunction

    // cache model, ready after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (mem_ready_i) begin
            // transfer lands on this edge
            if (mem_req_o.we) begin
                mem[mem_req_o.addr[5:2]] <= merge_bytes(mem[mem_req_o.addr[5:2]],
                                                        mem_req_o.wdata, mem_req_o.strb);
            end
            xfer_count  <= xfer_count + 1;
            mem_ready_i <= 1'b0;
        end else if (mem_req_valid_o) begin
            if (wait_left == 0) begin
                mem_ready_i <= 1'b1;
                mem_rdata_i <= mem[mem_req_o.addr[5:2]];
                wait_left   <= $random(seed) & 3;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // clint answers in the same cycle
    assign clint_rdata_i = clint_regs[clint_slot(clint_req_o.addr)];

    always @(posedge clk) begin
        if (clint_valid_o && clint_req_o.we) begin
            clint_regs[clint_slot(clint_req_o.addr)] <=
                merge_bytes(clint_regs[clint_slot(clint_req_o.addr)],
                            clint_req_o.wdata, clint_req_o.strb);
        end
    end

    task automatic plain_row(input lsu_op_pkg::memop_t op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_data,
                             input logic exp_misalign, input int exp_xfers);
        row_t r;
        r = {op, lsu_op_pkg::amoop_swap, addr, wdata, exp_data, exp_misalign, exp_xfers};
        rows.push_back(r);
    endtask

    task automatic amo_row(input lsu_op_pkg::amoop_t amo_op, input logic [31:0] addr,
                           input logic [31:0] operand, input logic [31:0] exp_old,
                           input logic exp_misalign, input int exp_xfers);
        row_t r;
        r = {lsu_op_pkg::memop_amo, amo_op, addr, operand, exp_old, exp_misalign, exp_xfers};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // merged stores on word 0x10, then extended loads
        plain_row(lsu_op_pkg::memop_sw, 32'h10, 32'h1122_3344, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sh, 32'h12, 32'h0000_abcd, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sb, 32'h11, 32'h0000_0080, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lw, 32'h10, 32'h0, 32'habcd_8044, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lh, 32'h12, 32'h0, 32'hffff_abcd, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lhu, 32'h12, 32'h0, 32'h0000_abcd, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lb, 32'h11, 32'h0, 32'hffff_ff80, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lbu, 32'h11, 32'h0, 32'h0000_0080, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lh, 32'h10, 32'h0, 32'hffff_8044, 1'b0, 1);
        // upper store bytes must not leak past the strobe
        plain_row(lsu_op_pkg::memop_sb, 32'h13, 32'h1234_567e, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lw, 32'h10, 32'h0, 32'h7ecd_8044, 1'b0, 1);
        // clint words bypass the cache
        plain_row(lsu_op_pkg::memop_sw, lsu_map_pkg::mtimecmp_lo_addr, 32'hcafe_f00d,
                  32'h0, 1'b0, 0);
        plain_row(lsu_op_pkg::memop_lw, lsu_map_pkg::mtimecmp_lo_addr, 32'h0,
                  32'hcafe_f00d, 1'b0, 0);
        plain_row(lsu_op_pkg::memop_lw, lsu_map_pkg::mtime_lo_addr, 32'h0,
                  32'h0001_2345, 1'b0, 0);
        // amo chain on word 0x20, each returns the old word
        plain_row(lsu_op_pkg::memop_sw, 32'h20, 32'hffff_fff0, 32'h0, 1'b0, 1);
        amo_row(lsu_op_pkg::amoop_add, 32'h20, 32'h0000_0020, 32'hffff_fff0, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_swap, 32'h20, 32'h8000_0001, 32'h0000_0010, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_xor, 32'h20, 32'hffff_0000, 32'h8000_0001, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_and, 32'h20, 32'h0f0f_0f0f, 32'h7fff_0001, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_or, 32'h20, 32'h3000_0100, 32'h0f0f_0001, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_min, 32'h20, 32'hffff_fffe, 32'h3f0f_0101, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_max, 32'h20, 32'h0000_0005, 32'hffff_fffe, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_minu, 32'h20, 32'hffff_fff0, 32'h0000_0005, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_maxu, 32'h20, 32'h8000_0000, 32'h0000_0005, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_min, 32'h20, 32'h0000_0007, 32'h8000_0000, 1'b0, 2);
        amo_row(lsu_op_pkg::amoop_minu, 32'h20, 32'h0000_0007, 32'h8000_0000, 1'b0, 2);
        plain_row(lsu_op_pkg::memop_lw, 32'h20, 32'h0, 32'h0000_0007, 1'b0, 1);
        // lr/sc pair that succeeds
        plain_row(lsu_op_pkg::memop_sw, 32'h30, 32'h0000_00aa, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lr_w, 32'h30, 32'h0, 32'h0000_00aa, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sc_w, 32'h30, 32'h0000_00bb, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lw, 32'h30, 32'h0, 32'h0000_00bb, 1'b0, 1);
        // store in between kills the reservation
        plain_row(lsu_op_pkg::memop_lr_w, 32'h30, 32'h0, 32'h0000_00bb, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sw, 32'h34, 32'h0000_0001, 32'h0, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sc_w, 32'h30, 32'h0000_00cc, 32'h1, 1'b0, 0);
        // sc to another word fails
        plain_row(lsu_op_pkg::memop_lr_w, 32'h30, 32'h0, 32'h0000_00bb, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_sc_w, 32'h34, 32'h0000_00dd, 32'h1, 1'b0, 0);
        // amo takes no reservation
        amo_row(lsu_op_pkg::amoop_add, 32'h30, 32'h0000_0001, 32'h0000_00bb, 1'b0, 2);
        plain_row(lsu_op_pkg::memop_sc_w, 32'h30, 32'h0000_00ee, 32'h1, 1'b0, 0);
        plain_row(lsu_op_pkg::memop_lw, 32'h30, 32'h0, 32'h0000_00bc, 1'b0, 1);
        plain_row(lsu_op_pkg::memop_lw, 32'h34, 32'h0, 32'h0000_0001, 1'b0, 1);
        // misaligned atomics, flagged with no transfer
        amo_row(lsu_op_pkg::amoop_add, 32'h22, 32'h0000_0001, 32'h0, 1'b1, 0);
        plain_row(lsu_op_pkg::memop_lr_w, 32'h31, 32'h0, 32'h0, 1'b1, 0);
        plain_row(lsu_op_pkg::memop_sc_w, 32'h32, 32'h0000_0055, 32'h0, 1'b1, 0);
        plain_row(lsu_op_pkg::memop_lw, 32'h20, 32'h0, 32'h0000_0007, 1'b0, 1);
    endtask

    // one strobe, wait for the response, compare
    task automatic run_row(input int n);
        row_t r;
        int   xfers_before;
        r = rows[n];
        xfers_before = xfer_count;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= {r.op, r.amo_op, r.addr, r.wdata};
        @(posedge clk);
        req_valid_i <= 1'b0;
        @(negedge clk);
        // busy from the cycle after the strobe
        checks = checks + 1;
        if (busy_o !== 1'b1) begin
            errors = errors + 1;
            $display("FAILED at %0t: row %0d busy_o = %b, expected %b",
                     $time, n, busy_o, 1'b1);
        end
        while (!resp_valid_o) begin
            @(negedge clk);
        end
        checks = checks + 3;
        if (resp_data_o !== r.exp_data) begin
            errors = errors + 1;
            $display("FAILED at %0t: row %0d resp_data_o = %h, expected %h",
                     $time, n, resp_data_o, r.exp_data);
        end
        if (resp_misalign_o !== r.exp_misalign) begin
            errors = errors + 1;
            $display("FAILED at %0t: row %0d resp_misalign_o = %b, expected %b",
                     $time, n, resp_misalign_o, r.exp_misalign);
        end
        if (xfer_count - xfers_before != r.exp_xfers) begin
            errors = errors + 1;
            $display("FAILED at %0t: row %0d cache transfers = %0d, expected %0d",
                     $time, n, xfer_count - xfers_before, r.exp_xfers);
        end
        // busy drops together with the response strobe
        @(negedge clk);
        checks = checks + 1;
        if (busy_o !== 1'b0) begin
            errors = errors + 1;
            $display("FAILED at %0t: row %0d busy_o = %b, expected %b",
                     $time, n, busy_o, 1'b0);
        end
    endtask

    initial begin
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        checks      = 0;
        errors      = 0;
        build_table();
        rows_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            run_row(i);
        end
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // budget of 12 cycles a row plus reset
    initial begin
        wait (rows_ready);
        repeat (rows.size() * 12 + 20) @(posedge clk);
        errors = errors + 1;
        $display("timeout: the DUT did not answer all table rows in time");
        $display("%0d checks, %0d errors", checks, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- vlog.f
src/lsu_map_pkg.sv
src/lsu_op_pkg.sv
src/lsu_decode.sv
src/lsu_lane.sv
src/amo_alu.sv
src/lsu_ctrl.sv
src/lsu_top.sv
testbench/tb_clock.sv
testbench/lsu_properties.sv
testbench/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lsu_tb -f vlog.f

./obj_dir/Vlsu_tb 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
